// ==== common/dcache_pkg.sv ====
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int NUM_WAYS       = 4;
    localparam int WAY_IDX_W      = $clog2(NUM_WAYS);
    localparam int NUM_SETS       = 128;
    localparam int SET_W          = 7;
    localparam int WORDS_PER_LINE = 16;
    localparam int WORD_SEL_W     = 4;
    localparam int BYTE_OFF_W     = 2;
    localparam int TAG_W          = ADDR_W - SET_W - WORD_SEL_W - BYTE_OFF_W;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;

    // tag entry is {tag, valid, dirty}
    localparam int TAG_ENTRY_W    = TAG_W + 2;

    typedef enum logic [2:0] {
        RESET_SWEEP,
        LOOKUP,
        WRITE_BACK,
        REFILL_REQ,
        REFILL_WRITE
    } ctrl_state_e;

    // lookup view of an address
    typedef struct packed {
        logic [TAG_W-1:0]      tag;
        logic [SET_W-1:0]      set;
        logic [WORD_SEL_W-1:0] word_sel;
        logic [BYTE_OFF_W-1:0] byte_off;
    } dcache_fields_t;

    // memory side view, line address above the line offset
    typedef struct packed {
        logic [ADDR_W-WORD_SEL_W-BYTE_OFF_W-1:0] line_addr;
        logic [WORD_SEL_W+BYTE_OFF_W-1:0]        line_off;
    } dcache_line_t;

    typedef union packed {
        dcache_fields_t f;
        dcache_line_t   l;
    } dcache_addr_u;

endpackage

// ==== common/array_port_if.sv ====
interface array_port_if
    import dcache_pkg::*;
();

    logic [SET_W-1:0]          set;
    logic [NUM_WAYS-1:0]       way_we;
    logic [WORDS_PER_LINE-1:0] bank_we;
    logic [LINE_W-1:0]         line_wdata;
    logic [TAG_W-1:0]          tag;
    logic                      entry_valid;
    logic                      entry_dirty;

    modport ctrl (
        output set, way_we, bank_we, line_wdata, tag, entry_valid, entry_dirty
    );

    // tag store compares and writes the cpu tag
    modport tag_side (
        input set, way_we, tag, entry_valid, entry_dirty
    );

    modport data_side (
        input set, way_we, bank_we, line_wdata
    );

endinterface

// ==== dcache/tag_store.sv ====
module tag_store
    import dcache_pkg::*;
(
    input  logic                                 clk,
    array_port_if.tag_side                       port,
    output logic [NUM_WAYS-1:0][TAG_ENTRY_W-1:0] entries,
    output logic [NUM_WAYS-1:0]                  hit_way
);

    logic [TAG_ENTRY_W-1:0] wr_entry;

    // all ways share the write entry, way_we picks the target
    assign wr_entry = {port.tag, port.entry_valid, port.entry_dirty};

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        logic [TAG_ENTRY_W-1:0] mem [NUM_SETS];
        logic [TAG_ENTRY_W-1:0] rdata;
        logic [TAG_W-1:0]       stored_tag;
        logic                   stored_valid;

        // synchronous read, write-first
        always_ff @(posedge clk) begin
            if (port.way_we[w]) begin
                mem[port.set] <= wr_entry;
                rdata         <= wr_entry;
            end else begin
                rdata <= mem[port.set];
            end
        end

        assign stored_tag   = rdata[TAG_ENTRY_W-1:2];
        assign stored_valid = rdata[1];

        assign entries[w] = rdata;
        assign hit_way[w] = stored_valid && (stored_tag == port.tag);
    end

endmodule

// ==== dcache/data_store.sv ====
module data_store
    import dcache_pkg::*;
(
    input  logic                            clk,
    array_port_if.data_side                 port,
    output logic [NUM_WAYS-1:0][LINE_W-1:0] lines
);

    // one word bank per way and word position
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < WORDS_PER_LINE; b++) begin : g_bank
            logic [WORD_W-1:0] mem [NUM_SETS];
            logic [WORD_W-1:0] wdata;
            logic [WORD_W-1:0] rdata;
            logic              we;

            assign we    = port.way_we[w] && port.bank_we[b];
            assign wdata = port.line_wdata[b*WORD_W +: WORD_W];

            always_ff @(posedge clk) begin
                if (we) begin
                    mem[port.set] <= wdata;
                    rdata         <= wdata;
                end else begin
                    rdata <= mem[port.set];
                end
            end

            assign lines[w][b*WORD_W +: WORD_W] = rdata;
        end
    end

endmodule

// ==== dcache/cache_ctrl.sv ====
module cache_ctrl
    import dcache_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic [ADDR_W-1:0]                    addr,
    input  logic                                 rd_req,
    input  logic                                 wr_req,
    input  logic [WORD_W-1:0]                    wr_data,
    input  logic [3:0]                           valid_lane,
    input  logic                                 mem_gnt,
    input  logic [LINE_W-1:0]                    mem_rd_data,

    // store read results
    input  logic [NUM_WAYS-1:0][TAG_ENTRY_W-1:0] entries,
    input  logic [NUM_WAYS-1:0][LINE_W-1:0]      lines,
    input  logic [NUM_WAYS-1:0]                  hit_way,

    array_port_if.ctrl                           port,

    output logic                                 miss,
    output logic [WORD_W-1:0]                    rd_data,
    output logic [ADDR_W-1:0]                    mem_addr,
    output logic                                 mem_rd_req,
    output logic                                 mem_wr_req,
    output logic [LINE_W-1:0]                    mem_wr_data,
    output logic [WORD_W-1:0]                    access_count,
    output logic [WORD_W-1:0]                    miss_count
);

    ctrl_state_e            state;
    ctrl_state_e            next_state;
    logic [SET_W-1:0]       sweep_cnt;
    logic [SET_W-1:0]       ram_set;
    logic [SET_W-1:0]       prev_set;
    logic [WAY_IDX_W-1:0]   victim_ptr [NUM_SETS];
    logic [WAY_IDX_W-1:0]   victim;
    logic [WAY_IDX_W-1:0]   hit_idx;
    logic [TAG_ENTRY_W-1:0] victim_entry;
    dcache_addr_u           req_addr;
    dcache_addr_u           wb_addr;
    dcache_addr_u           rf_addr;
    logic                   req;
    logic                   any_hit;
    logic                   set_ready;
    logic                   lookup_hit;
    logic [WORD_W-1:0]      hit_word;
    logic [WORD_W-1:0]      merged_word;

    assign req_addr = addr;
    assign req      = rd_req || wr_req;
    assign any_hit  = |hit_way;

    // the rams show the new set one cycle after it is presented
    assign ram_set    = (state == RESET_SWEEP) ? sweep_cnt : req_addr.f.set;
    assign set_ready  = (ram_set == prev_set);
    assign lookup_hit = (state == LOOKUP) && req && any_hit && set_ready;

    assign victim       = victim_ptr[req_addr.f.set];
    assign victim_entry = entries[victim];

    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way[w]) begin
                hit_idx = WAY_IDX_W'(w);
            end
        end
    end

    assign hit_word = lines[hit_idx][req_addr.f.word_sel*WORD_W +: WORD_W];
    assign rd_data  = hit_word;

    // byte lane merge over the stored word
    always_comb begin
        for (int i = 0; i < WORD_W / 8; i++) begin
            merged_word[i*8 +: 8] = valid_lane[i] ? wr_data[i*8 +: 8] : hit_word[i*8 +: 8];
        end
    end

    assign miss = rst || (state == RESET_SWEEP)
                || (req && ((state != LOOKUP) || !any_hit || !set_ready));

    always_comb begin
        next_state = state;
        case (state)
            RESET_SWEEP: begin
                if (sweep_cnt == SET_W'(NUM_SETS - 1)) begin
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req && set_ready && !any_hit) begin
                    // dirty bit of the victim entry
                    next_state = victim_entry[0] ? WRITE_BACK : REFILL_REQ;
                end
            end
            WRITE_BACK: begin
                if (mem_gnt) begin
                    next_state = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (mem_gnt) begin
                    next_state = REFILL_WRITE;
                end
            end
            REFILL_WRITE: next_state = LOOKUP;
            default:      next_state = LOOKUP;
        endcase
    end

    always_comb begin
        port.set         = ram_set;
        port.tag         = req_addr.f.tag;
        port.way_we      = '0;
        port.bank_we     = '0;
        port.line_wdata  = {WORDS_PER_LINE{merged_word}};
        port.entry_valid = 1'b0;
        port.entry_dirty = 1'b0;
        case (state)
            RESET_SWEEP: port.way_we = '1;
            LOOKUP: begin
                if (lookup_hit && wr_req) begin
                    port.way_we                     = hit_way;
                    port.bank_we[req_addr.f.word_sel] = 1'b1;
                    port.entry_valid                = 1'b1;
                    port.entry_dirty                = 1'b1;
                end
            end
            REFILL_WRITE: begin
                port.way_we[victim] = 1'b1;
                port.bank_we        = '1;
                port.line_wdata     = mem_rd_data;
                port.entry_valid    = 1'b1;
            end
            default: ;
        endcase
    end

    // memory addresses
    always_comb begin
        wb_addr.f.tag      = victim_entry[TAG_ENTRY_W-1:2];
        wb_addr.f.set      = req_addr.f.set;
        wb_addr.f.word_sel = '0;
        wb_addr.f.byte_off = '0;
        rf_addr.l.line_addr = req_addr.l.line_addr;
        rf_addr.l.line_off  = '0;
    end

    assign mem_addr    = (state == WRITE_BACK) ? wb_addr : rf_addr;
    assign mem_wr_data = lines[victim];
    assign mem_wr_req  = (state == WRITE_BACK);
    assign mem_rd_req  = (state == REFILL_REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RESET_SWEEP;
            sweep_cnt <= '0;
            prev_set  <= '0;
        end else begin
            state    <= next_state;
            prev_set <= ram_set;
            if (state == RESET_SWEEP) begin
                sweep_cnt <= sweep_cnt + 1'b1;
            end
        end
    end

    // round-robin victim, moves on when its way gets hit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                victim_ptr[s] <= '0;
            end
        end else if (lookup_hit && (hit_idx == victim)) begin
            victim_ptr[req_addr.f.set] <= victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            access_count <= '0;
            miss_count   <= '0;
        end else begin
            if (req && !miss) begin
                access_count <= access_count + 1'b1;
            end
            if ((state == LOOKUP) && (next_state != LOOKUP)) begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/dcache_top.sv ====
module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,

    // cpu side
    input  logic [ADDR_W-1:0] addr,
    input  logic              rd_req,
    input  logic              wr_req,
    input  logic [WORD_W-1:0] wr_data,
    input  logic [3:0]        valid_lane,
    output logic [WORD_W-1:0] rd_data,
    output logic              miss,

    // memory side
    input  logic              mem_gnt,
    input  logic [LINE_W-1:0] mem_rd_data,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              mem_rd_req,
    output logic              mem_wr_req,
    output logic [LINE_W-1:0] mem_wr_data,

    output logic [WORD_W-1:0] access_count,
    output logic [WORD_W-1:0] miss_count
);

    logic [NUM_WAYS-1:0][TAG_ENTRY_W-1:0] entries;
    logic [NUM_WAYS-1:0][LINE_W-1:0]      lines;
    logic [NUM_WAYS-1:0]                  hit_way;

    array_port_if array_port ();

    tag_store u_tags (
        .clk     (clk),
        .port    (array_port.tag_side),
        .entries (entries),
        .hit_way (hit_way)
    );

    data_store u_data (
        .clk   (clk),
        .port  (array_port.data_side),
        .lines (lines)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .wr_data      (wr_data),
        .valid_lane   (valid_lane),
        .mem_gnt      (mem_gnt),
        .mem_rd_data  (mem_rd_data),
        .entries      (entries),
        .lines        (lines),
        .hit_way      (hit_way),
        .port         (array_port.ctrl),
        .miss         (miss),
        .rd_data      (rd_data),
        .mem_addr     (mem_addr),
        .mem_rd_req   (mem_rd_req),
        .mem_wr_req   (mem_wr_req),
        .mem_wr_data  (mem_wr_data),
        .access_count (access_count),
        .miss_count   (miss_count)
    );

endmodule

// ==== verification/line_mem_model.sv ====
module line_mem_model
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [3:0]        gnt_delay,
    input  logic [ADDR_W-1:0] mem_addr,
    input  logic              mem_rd_req,
    input  logic              mem_wr_req,
    input  logic [LINE_W-1:0] mem_wr_data,
    output logic              mem_gnt,
    output logic [LINE_W-1:0] mem_rd_data,
    output logic [31:0]       refill_count,
    output logic [31:0]       writeback_count,
    output logic [9:0]        last_wb_line
);

    localparam int LINE_IDX_W = 10;
    localparam int NUM_LINES  = 1 << LINE_IDX_W;

    logic [LINE_W-1:0]     shadow [NUM_LINES];
    logic [LINE_IDX_W-1:0] line_idx;
    logic [3:0]            wait_cnt;
    logic                  gnt_q = 1'b0;
    logic [LINE_W-1:0]     rd_line_q = '0;

    // word value is a hash of the full word index
    function automatic logic [LINE_W-1:0] fill_line(input int idx);
        logic [LINE_W-1:0] fill;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            fill[w*WORD_W +: WORD_W] = WORD_W'(idx * WORDS_PER_LINE + w) * 32'h9E37_79B1
                                       + 32'h1357_2468;
        end
        return fill;
    endfunction

    assign line_idx    = mem_addr[BYTE_OFF_W+WORD_SEL_W +: LINE_IDX_W];
    assign mem_gnt     = gnt_q;
    assign mem_rd_data = rd_line_q;

    always @(posedge clk) begin
        if (rst) begin
            gnt_q           <= 1'b0;
            wait_cnt        <= '0;
            refill_count    <= '0;
            writeback_count <= '0;
            last_wb_line    <= '0;
            for (int l = 0; l < NUM_LINES; l++) begin
                shadow[l] <= fill_line(l);
            end
        end else begin
            gnt_q <= 1'b0;
            if (gnt_q && mem_wr_req) begin
                shadow[line_idx] <= mem_wr_data;
                last_wb_line     <= line_idx;
                writeback_count  <= writeback_count + 1;
            end
            // line shows up in the cycle after the grant
            if (gnt_q && mem_rd_req) begin
                rd_line_q    <= shadow[line_idx];
                refill_count <= refill_count + 1;
            end
            if ((mem_rd_req || mem_wr_req) && !gnt_q) begin
                if (wait_cnt >= gnt_delay) begin
                    gnt_q    <= 1'b1;
                    wait_cnt <= '0;
                end else begin
                    wait_cnt <= wait_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verification/dcache_tb.sv ====
module dcache_tb
    import dcache_pkg::*;
();

    localparam int PERIOD         = 40;
    localparam int DRIVE_DLY      = 5;
    localparam int RESET_CYCLES   = 10;
    localparam int RAND_OPS       = 200;
    localparam int DIRTY_SET      = 100;
    localparam int NUM_REQ        = 1 + 4 + 12 + 10 + RAND_OPS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_SETS + 200 * NUM_REQ;
    localparam int REF_IDX_W      = 14;
    localparam int REF_WORDS      = 1 << REF_IDX_W;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] addr;
    logic              rd_req;
    logic              wr_req;
    logic [WORD_W-1:0] wr_data;
    logic [3:0]        valid_lane;
    logic [WORD_W-1:0] rd_data;
    logic              miss;
    logic              mem_gnt;
    logic [LINE_W-1:0] mem_rd_data;
    logic [ADDR_W-1:0] mem_addr;
    logic              mem_rd_req;
    logic              mem_wr_req;
    logic [LINE_W-1:0] mem_wr_data;
    logic [WORD_W-1:0] access_count;
    logic [WORD_W-1:0] miss_count;
    logic [3:0]        gnt_delay;
    logic [31:0]       refill_count;
    logic [31:0]       writeback_count;
    logic [9:0]        last_wb_line;

    // cpu-visible memory, indexed by {tag[2:0], set, word}
    logic [WORD_W-1:0] ref_mem [REF_WORDS];
    logic [31:0]       seed = 32'd71177;
    int                accepted = 0;
    int                errors = 0;

    dcache_top dut0 (.*);

    line_mem_model mem_model0 (
        .clk             (clk),
        .rst             (rst),
        .gnt_delay       (gnt_delay),
        .mem_addr        (mem_addr),
        .mem_rd_req      (mem_rd_req),
        .mem_wr_req      (mem_wr_req),
        .mem_wr_data     (mem_wr_data),
        .mem_gnt         (mem_gnt),
        .mem_rd_data     (mem_rd_data),
        .refill_count    (refill_count),
        .writeback_count (writeback_count),
        .last_wb_line    (last_wb_line)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic logic [WORD_W-1:0] fill_word(input int idx);
        return WORD_W'(idx) * 32'h9E37_79B1 + 32'h1357_2468;
    endfunction

    function automatic logic [ADDR_W-1:0] make_addr(input int tag, input int set_idx,
                                                    input int word);
        dcache_addr_u a;
        a.f.tag      = TAG_W'(tag);
        a.f.set      = SET_W'(set_idx);
        a.f.word_sel = WORD_SEL_W'(word);
        a.f.byte_off = '0;
        return a;
    endfunction

    function automatic int ref_index(input logic [ADDR_W-1:0] a);
        return int'(a[BYTE_OFF_W +: REF_IDX_W]);
    endfunction

    function automatic logic [WORD_W-1:0] merge_lanes(input logic [WORD_W-1:0] old_word,
                                                      input logic [WORD_W-1:0] new_word,
                                                      input logic [3:0] lanes);
        logic [WORD_W-1:0] result;
        for (int i = 0; i < 4; i++) begin
            result[i*8 +: 8] = lanes[i] ? new_word[i*8 +: 8] : old_word[i*8 +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("FAILED at time %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic access_word(input logic is_write, input logic [ADDR_W-1:0] a,
                               input logic [WORD_W-1:0] data, input logic [3:0] lanes,
                               input logic [3:0] delay);
        dcache_addr_u line_view;
        dcache_addr_u mem_view;
        int           idx;
        line_view = a;
        line_view.l.line_off = '0;
        idx = ref_index(a);
        @(posedge clk);
        #(DRIVE_DLY);
        addr       = a;
        rd_req     = !is_write;
        wr_req     = is_write;
        wr_data    = data;
        valid_lane = lanes;
        gnt_delay  = delay;
        @(negedge clk);
        // request is held while miss is high
        while (miss) begin
            mem_view = mem_addr;
            if (mem_rd_req) begin
                check_value("mem_addr on refill", mem_addr, line_view);
            end
            if (mem_wr_req) begin
                check_value("mem_addr set on write-back", mem_view.f.set, line_view.f.set);
            end
            @(negedge clk);
        end
        check_value("mem_rd_req at accept", mem_rd_req, 0);
        check_value("mem_wr_req at accept", mem_wr_req, 0);
        if (is_write) begin
            ref_mem[idx] = merge_lanes(ref_mem[idx], data, lanes);
        end else begin
            check_value("rd_data", rd_data, ref_mem[idx]);
        end
        accepted++;
    endtask

    task automatic release_request();
        @(posedge clk);
        #(DRIVE_DLY);
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        valid_lane = '0;
    endtask

    task automatic read_with_refill(input int tag, input int set_idx, input int word);
        logic [31:0] miss_before;
        logic [31:0] rf_before;
        miss_before = miss_count;
        rf_before   = refill_count;
        access_word(1'b0, make_addr(tag, set_idx, word), '0, 4'h0, 4'd3);
        check_value("miss_count", miss_count, miss_before + 1);
        check_value("refill_count", refill_count, rf_before + 1);
    endtask

    task automatic reset_and_sweep();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            #(DRIVE_DLY);
            check_value("miss in reset", miss, 1);
            check_value("mem_rd_req in reset", mem_rd_req, 0);
            check_value("mem_wr_req in reset", mem_wr_req, 0);
        end
        rst = 1'b0;
        repeat (NUM_SETS) begin
            @(negedge clk);
            check_value("miss in sweep", miss, 1);
            check_value("mem_rd_req in sweep", mem_rd_req, 0);
            check_value("mem_wr_req in sweep", mem_wr_req, 0);
        end
        @(negedge clk);
        check_value("miss after sweep", miss, 0);
        check_value("access_count after reset", access_count, 0);
        check_value("miss_count after reset", miss_count, 0);
        read_with_refill(0, 0, 0);
    endtask

    task automatic clean_refill();
        read_with_refill(1, 5, 3);
        read_with_refill(2, 6, 15);
        read_with_refill(7, 127, 0);
        read_with_refill(3, 0, 9);
    endtask

    task automatic byte_lane_writes();
        logic [31:0] rf_before;
        logic [31:0] wb_before;
        logic [31:0] miss_before;
        logic [3:0]  lanes;
        rf_before   = refill_count;
        wb_before   = writeback_count;
        miss_before = miss_count;
        // each word gets a single lane, then the other three
        for (int i = 0; i < 8; i++) begin
            lanes = (i < 4) ? (4'b0001 << i) : ~(4'b0001 << (i - 4));
            access_word(1'b1, make_addr(1, 5, i % 4), next_rand(), lanes, 4'd1);
        end
        for (int i = 0; i < 4; i++) begin
            access_word(1'b0, make_addr(1, 5, i), '0, 4'h0, 4'd1);
        end
        check_value("refill_count on hits", refill_count, rf_before);
        check_value("writeback_count on hits", writeback_count, wb_before);
        check_value("miss_count on hits", miss_count, miss_before);
    endtask

    task automatic dirty_eviction();
        logic [31:0]       wb_before;
        logic [ADDR_W-1:0] first_addr;
        wb_before  = writeback_count;
        first_addr = make_addr(0, DIRTY_SET, 0);
        for (int t = 0; t < 5; t++) begin
            access_word(1'b1, make_addr(t, DIRTY_SET, t), next_rand(), 4'hF, 4'd2);
        end
        // four tags fill the ways, the fifth pushes out tag 0
        check_value("writeback_count", writeback_count, wb_before + 1);
        check_value("last_wb_line", last_wb_line, first_addr[15:6]);
        for (int t = 0; t < 5; t++) begin
            access_word(1'b0, make_addr(t, DIRTY_SET, t), '0, 4'h0, 4'd2);
        end
    endtask

    task automatic back_pressure_traffic();
        logic [31:0] r;
        logic [31:0] data;
        logic [31:0] ctl;
        for (int i = 0; i < RAND_OPS; i++) begin
            r    = next_rand();
            data = next_rand();
            ctl  = next_rand();
            access_word(r[31], make_addr(int'(r[30:28]), 20 + int'(r[27:12]) % 3,
                        int'(r[11:8])), data, ctl[31:28], ctl[27:24] % 8);
        end
    endtask

    task automatic counter_totals();
        release_request();
        @(negedge clk);
        check_value("access_count", access_count, accepted);
        check_value("miss_count", miss_count, refill_count);
    endtask

    // written-back lines hold what the cpu wrote
    always @(negedge clk) begin
        if (!rst && mem_wr_req && mem_gnt) begin
            check_value("mem_addr upper bits", mem_addr[ADDR_W-1:16], 0);
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                check_value("mem_wr_data", mem_wr_data[w*WORD_W +: WORD_W],
                            ref_mem[ref_index(mem_addr) + w]);
            end
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        addr       = '0;
        rd_req     = 1'b0;
        wr_req     = 1'b0;
        wr_data    = '0;
        valid_lane = '0;
        gnt_delay  = '0;
        for (int i = 0; i < REF_WORDS; i++) begin
            ref_mem[i] = fill_word(i);
        end
        reset_and_sweep();
        clean_refill();
        byte_lane_writes();
        dirty_eviction();
        back_pressure_traffic();
        counter_totals();
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
common/dcache_pkg.sv
common/array_port_if.sv
dcache/tag_store.sv
dcache/data_store.sv
dcache/cache_ctrl.sv
hdl/dcache_top.sv
verification/line_mem_model.sv
verification/dcache_tb.sv
